//--- Bender.yml
package:
  name: pixelGen

sources:
  - src/pixelPkg.sv
  - src/screenControl.sv
  - src/digitSegments.sv
  - src/digitRaster.sv
  - src/pixelMux.sv
  - src/pixelGenTop.sv
  - target: simulation
    files:
      - sim/pixelChecker.sv
      - sim/pixelGenTb.sv

//--- pixelGenTop.f
src/pixelPkg.sv
src/screenControl.sv
src/digitSegments.sv
src/digitRaster.sv
src/pixelMux.sv
src/pixelGenTop.sv
sim/pixelChecker.sv
sim/pixelGenTb.sv

//--- sim/pixelCases.txt
// state theme score0 score1 cnt0 hCnt vCnt valid expectedRgb, all hex
// states: 1 bRst, 2 bPlay, 3 stage1, 4 stage2, 6 pmode, 7 win, 8 lose, 9 finish
2 0 0 0 8 12c a0  0 000  // valid low
7 1 0 0 0 64  64  0 000
1 1 3 4 5 12c a0  1 000  // bRst blanks
1 0 0 0 0 12c a0  1 000
2 0 0 0 8 12c a0  1 fff  // countdown top bar
2 0 0 0 0 12c f0  1 000
2 0 0 0 0 118 f0  1 fff  // middle left corner of 0
2 1 0 0 1 118 c8  1 fff
2 1 0 0 1 168 c8  1 000
2 0 0 0 7 168 f0  1 fff
2 0 0 0 7 118 f0  1 000
2 1 0 0 2 118 118 1 000
2 1 0 0 8 140 c8  1 fff  // inside the hole of 8
2 0 0 0 5 12c 140 1 fff
3 0 0 1 0 140 d2  1 fff  // score1 upper right
3 0 0 1 0 12c c3  1 000
6 1 4 0 0 159 eb  1 000
6 1 0 3 0 168 eb  1 fff
3 1 8 8 0 14a eb  1 fff  // gap between digits
3 0 0 7 0 181 fa  1 fff
6 0 9 3 0 12c 113 1 fff
4 1 8 8 8 12c a0  1 fff  // fill states
9 2 8 8 8 12c a0  1 000
8 3 8 8 8 168 c8  1 000
2 1 0 0 a 12c a0  1 fff  // digit above 9
3 1 0 f 0 118 d2  1 fff

//--- sim/pixelChecker.sv
`timescale 1ns/1ps

module pixelChecker #(
    parameter int latency = 2
) (
    input  logic            clk,
    input  logic            expCheck,
    input  pixelPkg::colorT expColor,
    input  logic [3:0]      vgaRed,
    input  logic [3:0]      vgaGreen,
    input  logic [3:0]      vgaBlue,
    output int              checkCount,
    output int              errorCount
);
    import pixelPkg::*;

    logic  checkPipe [0:latency-1];  // index 0 is the newest sample
    colorT colorPipe [0:latency-1];

    initial begin
        for (int i = 0; i < latency; i++) begin
            checkPipe[i] = 1'b0;
            colorPipe[i] = colorBlack;
        end
        checkCount = 0;
        errorCount = 0;
    end

    task automatic compareChannel(input string name, input logic [3:0] got,
                                  input logic [3:0] exp);
        if (got !== exp) begin
            errorCount++;
            $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    // expected values follow the DUT pipeline
    always @(posedge clk) begin
        checkPipe[0] <= expCheck;
        colorPipe[0] <= expColor;
        for (int i = 1; i < latency; i++) begin
            checkPipe[i] <= checkPipe[i-1];
            colorPipe[i] <= colorPipe[i-1];
        end
    end

    always @(negedge clk) begin
        if (checkPipe[latency-1]) begin
            checkCount++;
            compareChannel("vgaRed",   vgaRed,   colorPipe[latency-1][11:8]);
            compareChannel("vgaGreen", vgaGreen, colorPipe[latency-1][7:4]);
            compareChannel("vgaBlue",  vgaBlue,  colorPipe[latency-1][3:0]);
        end
    end

endmodule

//--- sim/pixelGenTb.sv
`timescale 1ns/1ps

module pixelGenTb;
    import pixelPkg::*;

    localparam int clkPeriod   = 8;
    localparam int resetCycles = 16;
    localparam int latency     = 2;
    localparam int maxCases    = 64;
    localparam int caseFields  = 9;  // words per line of the case file

    logic        clk;
    logic        rstN;
    pixelCoordT  hCnt, vCnt;
    logic        valid;
    themeT       theme;
    gameStateE   state;
    digitT       score0, score1, cnt0;
    logic [3:0]  vgaRed, vgaGreen, vgaBlue;
    logic        expCheck;
    colorT       expColor;
    int          checkCount, errorCount;
    int          numCases;
    logic        casesLoaded;
    logic        loadFailed;
    logic [15:0] caseMem [0:maxCases*caseFields-1];

    pixelGenTop dut (
        .clk(clk), .rstN(rstN), .hCnt(hCnt), .vCnt(vCnt), .valid(valid),
        .theme(theme), .state(state), .score0(score0), .score1(score1), .cnt0(cnt0),
        .vgaRed(vgaRed), .vgaGreen(vgaGreen), .vgaBlue(vgaBlue)
    );

    pixelChecker #(.latency(latency)) pixCheck (
        .clk(clk), .expCheck(expCheck), .expColor(expColor),
        .vgaRed(vgaRed), .vgaGreen(vgaGreen), .vgaBlue(vgaBlue),
        .checkCount(checkCount), .errorCount(errorCount)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // case file
    ////////////////////////////////////////////////////////////////////////////

    task automatic loadCases();
        for (int i = 0; i < maxCases * caseFields; i++)
            caseMem[i] = 16'hffff;  // end marker
        $readmemh("sim/pixelCases.txt", caseMem);
        numCases = 0;
        while (numCases < maxCases && caseMem[numCases * caseFields] != 16'hffff)
            numCases++;
    endtask

    task automatic driveCase(input int idx);
        int base;
        base     = idx * caseFields;
        state    = gameStateE'(caseMem[base][3:0]);
        theme    = caseMem[base+1][1:0];
        score0   = caseMem[base+2][3:0];
        score1   = caseMem[base+3][3:0];
        cnt0     = caseMem[base+4][3:0];
        hCnt     = caseMem[base+5][9:0];
        vCnt     = caseMem[base+6][9:0];
        valid    = caseMem[base+7][0];
        expColor = caseMem[base+8][11:0];
        expCheck = 1'b1;
    endtask

    initial begin
        rstN        = 1'b0;
        hCnt        = '0;
        vCnt        = '0;
        valid       = 1'b0;
        theme       = '0;
        state       = rst;
        score0      = '0;
        score1      = '0;
        cnt0        = '0;
        expCheck    = 1'b1;  // outputs stay black through reset
        expColor    = colorBlack;
        casesLoaded = 1'b0;
        loadFailed  = 1'b0;
        loadCases();
        casesLoaded = 1'b1;
        if (numCases == 0) begin
            loadFailed = 1'b1;
            $display("no cases could be read from sim/pixelCases.txt");
        end

        repeat (resetCycles) @(negedge clk);
        rstN = 1'b1;
        for (int i = 0; i < numCases; i++) begin
            driveCase(i);  // back to back, one pixel per cycle
            @(negedge clk);
        end
        expCheck = 1'b0;
        repeat (latency + 2) @(negedge clk);  // drain the pipeline

        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0 && !loadFailed) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (casesLoaded);
        #((numCases + resetCycles + 10) * clkPeriod);
        $display("timeout, the cases did not finish in time (checks %0d, errors %0d)",
                 checkCount, errorCount);
        $display("** FAIL **");
        $finish;
    end

endmodule

//--- src/digitRaster.sv
`timescale 1ns/1ps

module digitRaster #(
    parameter int originX     = 0,
    parameter int originY     = 0,
    parameter int barWidth    = pixelPkg::smallBar,
    parameter int digitWidth  = pixelPkg::smallWidth,
    parameter int digitHeight = pixelPkg::smallHeight
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  pixelPkg::pixelCoordT hCnt,
    input  pixelPkg::pixelCoordT vCnt,
    output pixelPkg::segMaskT    segHit
);
    import pixelPkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // digit geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam pixelCoordT colLeft   = pixelCoordT'(originX);
    localparam pixelCoordT colCentre = pixelCoordT'(originX + barWidth);
    localparam pixelCoordT colRight  = pixelCoordT'(originX + digitWidth - barWidth);
    localparam pixelCoordT colEnd    = pixelCoordT'(originX + digitWidth);

    localparam pixelCoordT rowTop    = pixelCoordT'(originY);
    localparam pixelCoordT rowTopEnd = pixelCoordT'(originY + barWidth);
    localparam pixelCoordT rowMid    = pixelCoordT'(originY + (digitHeight - barWidth) / 2);
    localparam pixelCoordT rowMidEnd = pixelCoordT'(originY + (digitHeight - barWidth) / 2
                                                    + barWidth);
    localparam pixelCoordT rowBot    = pixelCoordT'(originY + digitHeight - barWidth);
    localparam pixelCoordT rowEnd    = pixelCoordT'(originY + digitHeight);

    logic    inLeft, inCentre, inRight;
    logic    aboveMid, inMid, belowMid;
    logic    inTop, inBottom;
    segMaskT hitNext;

    assign inLeft   = (hCnt >= colLeft)   && (hCnt < colCentre);
    assign inCentre = (hCnt >= colCentre) && (hCnt < colRight);
    assign inRight  = (hCnt >= colRight)  && (hCnt < colEnd);

    assign aboveMid = (vCnt >= rowTop)    && (vCnt < rowMid);
    assign inMid    = (vCnt >= rowMid)    && (vCnt < rowMidEnd);
    assign belowMid = (vCnt >= rowMidEnd) && (vCnt < rowEnd);
    assign inTop    = (vCnt >= rowTop)    && (vCnt < rowTopEnd);
    assign inBottom = (vCnt >= rowBot)    && (vCnt < rowEnd);

    always_comb begin
        hitNext    = '0;
        hitNext[5] = inLeft & aboveMid;
        hitNext[8] = inLeft & inMid;     // left corner
        hitNext[4] = inLeft & belowMid;
        hitNext[1] = inRight & aboveMid;
        hitNext[7] = inRight & inMid;    // right corner
        hitNext[2] = inRight & belowMid;
        hitNext[0] = inCentre & inTop;
        hitNext[6] = inCentre & inMid;
        hitNext[3] = inCentre & inBottom;
    end

    always_ff @(posedge clk) begin
        if (!rstN)
            segHit <= '0;
        else
            segHit <= hitNext;
    end

    // regions must not overlap for any placement
    hitOneHot: assert property (
        @(posedge clk) disable iff (!rstN) $onehot0(segHit)
    ) else $error("pixel hit more than one segment region");

endmodule

//--- src/digitSegments.sv
`timescale 1ns/1ps

module digitSegments (
    input  logic              clk,
    input  logic              rstN,
    input  pixelPkg::digitT   digit,
    output pixelPkg::segMaskT litMask
);
    import pixelPkg::*;

    logic [6:0] segs;  // g f e d c b a
    segMaskT    maskNext;

    always_comb begin
        case (digit)
            4'd0:    segs = 7'h3f;
            4'd1:    segs = 7'h06;
            4'd2:    segs = 7'h5b;
            4'd3:    segs = 7'h4f;
            4'd4:    segs = 7'h66;
            4'd5:    segs = 7'h6d;
            4'd6:    segs = 7'h7d;
            4'd7:    segs = 7'h07;
            4'd8:    segs = 7'h7f;
            4'd9:    segs = 7'h6f;
            default: segs = 7'h00;  // blank digit
        endcase
        // corners fill in where a middle bar or both verticals meet
        maskNext = {segs[6] | (segs[4] & segs[5]),
                    segs[6] | (segs[1] & segs[2]),
                    segs};
    end

    always_ff @(posedge clk) begin
        if (!rstN)
            litMask <= '0;
        else
            litMask <= maskNext;
    end

endmodule

//--- src/pixelGenTop.sv
`timescale 1ns/1ps

module pixelGenTop #(
    parameter int bigX   = 270,  // countdown digit
    parameter int bigY   = 150,
    parameter int leftX  = 275,  // score1
    parameter int leftY  = 190,
    parameter int rightX = 340,  // score0
    parameter int rightY = 190
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  pixelPkg::pixelCoordT hCnt,
    input  pixelPkg::pixelCoordT vCnt,
    input  logic                 valid,
    input  pixelPkg::themeT      theme,
    input  pixelPkg::gameStateE  state,
    input  pixelPkg::digitT      score0,
    input  pixelPkg::digitT      score1,
    input  pixelPkg::digitT      cnt0,
    output logic [3:0]           vgaRed,
    output logic [3:0]           vgaGreen,
    output logic [3:0]           vgaBlue
);
    import pixelPkg::*;

    screenModeE mode;
    colorT      bgColor, fgColor;
    logic       pixValid;
    segMaskT    bigHit, leftHit, rightHit;
    segMaskT    cntLit, leftLit, rightLit;

    ////////////////////////////////////////////////////////////////////////////
    // stage one
    ////////////////////////////////////////////////////////////////////////////

    screenControl ctrl (
        .clk(clk), .rstN(rstN), .state(state), .theme(theme), .valid(valid),
        .mode(mode), .bgColor(bgColor), .fgColor(fgColor), .pixValid(pixValid)
    );

    digitRaster #(
        .originX(bigX), .originY(bigY),
        .barWidth(bigBar), .digitWidth(bigWidth), .digitHeight(bigHeight)
    ) bigRaster (
        .clk(clk), .rstN(rstN), .hCnt(hCnt), .vCnt(vCnt), .segHit(bigHit)
    );

    digitRaster #(
        .originX(leftX), .originY(leftY),
        .barWidth(smallBar), .digitWidth(smallWidth), .digitHeight(smallHeight)
    ) leftRaster (
        .clk(clk), .rstN(rstN), .hCnt(hCnt), .vCnt(vCnt), .segHit(leftHit)
    );

    digitRaster #(
        .originX(rightX), .originY(rightY),
        .barWidth(smallBar), .digitWidth(smallWidth), .digitHeight(smallHeight)
    ) rightRaster (
        .clk(clk), .rstN(rstN), .hCnt(hCnt), .vCnt(vCnt), .segHit(rightHit)
    );

    digitSegments cntSeg   (.clk(clk), .rstN(rstN), .digit(cnt0),   .litMask(cntLit));
    digitSegments leftSeg  (.clk(clk), .rstN(rstN), .digit(score1), .litMask(leftLit));
    digitSegments rightSeg (.clk(clk), .rstN(rstN), .digit(score0), .litMask(rightLit));

    ////////////////////////////////////////////////////////////////////////////
    // stage two
    ////////////////////////////////////////////////////////////////////////////

    pixelMux mux (
        .clk(clk), .rstN(rstN),
        .mode(mode), .bgColor(bgColor), .fgColor(fgColor), .pixValid(pixValid),
        .bigHit(bigHit), .leftHit(leftHit), .rightHit(rightHit),
        .cntLit(cntLit), .leftLit(leftLit), .rightLit(rightLit),
        .vgaRed(vgaRed), .vgaGreen(vgaGreen), .vgaBlue(vgaBlue)
    );

endmodule

//--- src/pixelMux.sv
`timescale 1ns/1ps

module pixelMux (
    input  logic                 clk,
    input  logic                 rstN,
    input  pixelPkg::screenModeE mode,
    input  pixelPkg::colorT      bgColor,
    input  pixelPkg::colorT      fgColor,
    input  logic                 pixValid,
    input  pixelPkg::segMaskT    bigHit,
    input  pixelPkg::segMaskT    leftHit,
    input  pixelPkg::segMaskT    rightHit,
    input  pixelPkg::segMaskT    cntLit,
    input  pixelPkg::segMaskT    leftLit,
    input  pixelPkg::segMaskT    rightLit,
    output logic [3:0]           vgaRed,
    output logic [3:0]           vgaGreen,
    output logic [3:0]           vgaBlue
);
    import pixelPkg::*;

    logic  cntOn;
    logic  scoreOn;
    colorT pixNext;

    assign cntOn   = |(bigHit & cntLit);
    assign scoreOn = (|(leftHit & leftLit)) | (|(rightHit & rightLit));

    always_comb begin
        if (!pixValid) begin
            pixNext = colorBlack;  // outside the visible area
        end else begin
            case (mode)
                blank:     pixNext = colorBlack;
                countdown: pixNext = cntOn ? fgColor : bgColor;
                score:     pixNext = scoreOn ? fgColor : bgColor;
                default:   pixNext = bgColor;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stage two output register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstN)
            {vgaRed, vgaGreen, vgaBlue} <= '0;
        else
            {vgaRed, vgaGreen, vgaBlue} <= pixNext;
    end

    // blanking must reach the DAC one cycle on
    blankOut: assert property (
        @(posedge clk) disable iff (!rstN)
        !pixValid |=> ({vgaRed, vgaGreen, vgaBlue} == 12'h000)
    ) else $error("rgb not black after invalid pixel");

endmodule

//--- src/pixelPkg.sv
package pixelPkg;

    ////////////////////////////////////////////////////////////////////////////
    // basic types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [9:0]  pixelCoordT;
    typedef logic [3:0]  digitT;      // above 9 shows blank
    typedef logic [1:0]  themeT;      // 1 light, rest dark
    typedef logic [11:0] colorT;      // {red, green, blue}

    // 0 top, 1 upper right, 2 lower right, 3 bottom, 4 lower left,
    // 5 upper left, 6 middle, 7 middle right corner, 8 middle left corner
    typedef logic [8:0]  segMaskT;

    typedef enum logic [3:0] {
        rst    = 4'd0,
        bRst   = 4'd1,
        bPlay  = 4'd2,
        stage1 = 4'd3,
        stage2 = 4'd4,
        stage3 = 4'd5,
        pmode  = 4'd6,
        win    = 4'd7,
        lose   = 4'd8,
        finish = 4'd9
    } gameStateE;

    typedef enum logic [1:0] {
        blank     = 2'd0,
        countdown = 2'd1,
        score     = 2'd2,
        fill      = 2'd3
    } screenModeE;

    ////////////////////////////////////////////////////////////////////////////
    // constants
    ////////////////////////////////////////////////////////////////////////////

    localparam colorT colorBlack = 12'h000;
    localparam colorT colorWhite = 12'hfff;

    localparam int bigBar      = 20;  // countdown digit
    localparam int bigWidth    = 100;
    localparam int bigHeight   = 180;
    localparam int smallBar    = 10;  // score digits
    localparam int smallWidth  = 50;
    localparam int smallHeight = 90;

endpackage

//--- src/screenControl.sv
`timescale 1ns/1ps

module screenControl (
    input  logic                   clk,
    input  logic                   rstN,
    input  pixelPkg::gameStateE    state,
    input  pixelPkg::themeT        theme,
    input  logic                   valid,
    output pixelPkg::screenModeE   mode,
    output pixelPkg::colorT        bgColor,
    output pixelPkg::colorT        fgColor,
    output logic                   pixValid
);
    import pixelPkg::*;

    screenModeE modeNext;
    colorT      bgNext;

    // game state to screen mode
    always_comb begin
        case (state)
            bRst:          modeNext = blank;
            bPlay:         modeNext = countdown;
            stage1, pmode: modeNext = score;
            default:       modeNext = fill;
        endcase
    end

    assign bgNext = (theme == 2'd1) ? colorWhite : colorBlack; // light theme

    ////////////////////////////////////////////////////////////////////////////
    // stage one registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstN) begin
            mode     <= blank;
            pixValid <= 1'b0;
        end else begin
            mode     <= modeNext;
            pixValid <= valid;
        end
    end

    always_ff @(posedge clk) begin
        bgColor <= bgNext;
        fgColor <= ~bgNext;  // always the opposite
    end

    // mode feeds the colour select downstream
    modeKnown: assert property (
        @(posedge clk) disable iff (!rstN) !$isunknown(mode)
    ) else $error("screen mode unknown");

endmodule
